// File: common/mem_pipe_pkg.sv
package mem_pipe_pkg;

    // data path and register file widths
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    // byte address width of the data memory, 8 KiB by default
    localparam int DEFAULT_MEM_ADDR_W = 13;

    // number of bytes and halves in one data word
    localparam int WORD_BYTES = DATA_W / 8;
    localparam int WORD_HALVES = DATA_W / 16;

    // access width of a load or store
    // code 2'b10 is not named and decodes as a full word
    typedef enum logic [1:0] {
        WIDTH_BYTE = 2'b00,
        WIDTH_HALF = 2'b01,
        WIDTH_WORD = 2'b11
    } access_width_e;

    // one memory word seen three ways
    // element 0 of each array sits at the lowest byte address
    typedef union packed {
        logic [DATA_W-1:0]                   word;
        logic [WORD_HALVES-1:0][15:0]        halves;
        logic [WORD_BYTES-1:0][7:0]          bytes;
    } mem_word_u;

endpackage

// File: src/ex_mem_register.sv
`timescale 1ns/1ps

module ex_mem_register import mem_pipe_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_halt,

    // memory stage controls
    input  logic                  i_mem_read,
    input  logic                  i_mem_write,
    input  logic                  i_unsigned_load,
    input  access_width_e         i_width,

    // write-back controls
    input  logic                  i_mem_to_reg,
    input  logic                  i_reg_write,

    // execute results
    input  logic [DATA_W-1:0]     i_alu_result,
    input  logic [DATA_W-1:0]     i_store_data,
    input  logic [REG_ADDR_W-1:0] i_reg_dest,

    output logic                  o_mem_read,
    output logic                  o_mem_write,
    output logic                  o_unsigned_load,
    output access_width_e         o_width,
    output logic                  o_mem_to_reg,
    output logic                  o_reg_write,
    output logic [DATA_W-1:0]     o_alu_result,
    output logic [DATA_W-1:0]     o_store_data,
    output logic [REG_ADDR_W-1:0] o_reg_dest
);

    // cleared controls form a bubble: no memory write, no register write
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_mem_read      <= 1'b0;
            o_mem_write     <= 1'b0;
            o_unsigned_load <= 1'b0;
            o_width         <= WIDTH_BYTE;
            o_mem_to_reg    <= 1'b0;
            o_reg_write     <= 1'b0;
            o_alu_result    <= '0;
            o_store_data    <= '0;
            o_reg_dest      <= '0;
        end else if (!i_halt) begin
            o_mem_read      <= i_mem_read;
            o_mem_write     <= i_mem_write;
            o_unsigned_load <= i_unsigned_load;
            o_width         <= i_width;
            o_mem_to_reg    <= i_mem_to_reg;
            o_reg_write     <= i_reg_write;
            o_alu_result    <= i_alu_result;
            o_store_data    <= i_store_data;
            o_reg_dest      <= i_reg_dest;
        end
    end

endmodule

// File: data_memory/data_ram.sv
`timescale 1ns/1ps

module data_ram import mem_pipe_pkg::*; #(
    parameter int MEM_ADDR_W = DEFAULT_MEM_ADDR_W
) (
    input  logic                  i_clk,
    input  logic                  i_we,
    input  access_width_e         i_width,
    input  logic [MEM_ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0]     i_data,
    output mem_word_u             o_data
);

    localparam int DEPTH = 2 ** MEM_ADDR_W;

    logic [7:0]            mem [DEPTH];

    // addresses of the four bytes of a word access, wrapping at the top
    logic [MEM_ADDR_W-1:0] byte_addr [WORD_BYTES];

    logic                  wr_half;
    logic                  wr_word;

    always_comb begin
        for (int k = 0; k < WORD_BYTES; k++) begin
            byte_addr[k] = i_addr + MEM_ADDR_W'(k);
        end
    end

    // a half also writes byte 1, anything wider than a half is a word
    assign wr_half = (i_width != WIDTH_BYTE);
    assign wr_word = (i_width != WIDTH_BYTE) && (i_width != WIDTH_HALF);

    // little-endian store, low byte at the lowest address
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[byte_addr[0]] <= i_data[7:0];
            if (wr_half) begin
                mem[byte_addr[1]] <= i_data[15:8];
            end
            if (wr_word) begin
                mem[byte_addr[2]] <= i_data[23:16];
                mem[byte_addr[3]] <= i_data[31:24];
            end
        end
    end

    // asynchronous read of four bytes from i_addr upward
    always_comb begin
        for (int k = 0; k < WORD_BYTES; k++) begin
            o_data.bytes[k] = mem[byte_addr[k]];
        end
    end

endmodule

// File: data_memory/mem_access.sv
`timescale 1ns/1ps

module mem_access import mem_pipe_pkg::*; #(
    parameter int MEM_ADDR_W = DEFAULT_MEM_ADDR_W
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_halt,

    // memory stage controls from EX/MEM
    input  logic                  i_mem_read,
    input  logic                  i_mem_write,
    input  logic                  i_unsigned_load,
    input  access_width_e         i_width,

    // write-back controls, only carried through
    input  logic                  i_mem_to_reg,
    input  logic                  i_reg_write,

    input  logic [DATA_W-1:0]     i_alu_result,
    input  logic [DATA_W-1:0]     i_store_data,
    input  logic [REG_ADDR_W-1:0] i_reg_dest,

    // debug port, valid while halted
    input  logic [DATA_W-1:0]     i_debug_addr,

    // MEM/WB register outputs
    output logic [DATA_W-1:0]     o_load_data,
    output logic [DATA_W-1:0]     o_alu_result,
    output logic [REG_ADDR_W-1:0] o_reg_dest,
    output logic                  o_mem_to_reg,
    output logic                  o_reg_write,

    output mem_word_u             o_debug_word
);

    logic [MEM_ADDR_W-1:0] mem_addr;
    logic                  mem_we;
    mem_word_u             read_word;
    logic [DATA_W-1:0]     load_ext;

    // address alignment
    // halted: the debug unit owns the memory port and reads whole words
    always_comb begin
        if (i_halt) begin
            mem_addr = {i_debug_addr[MEM_ADDR_W-1:2], 2'b00};
        end else begin
            case (i_width)
                WIDTH_BYTE: mem_addr = i_alu_result[MEM_ADDR_W-1:0];
                WIDTH_HALF: mem_addr = {i_alu_result[MEM_ADDR_W-1:1], 1'b0};
                default:    mem_addr = {i_alu_result[MEM_ADDR_W-1:2], 2'b00};
            endcase
        end
    end

    // no store may land while the pipeline is frozen
    assign mem_we = i_mem_write && !i_halt;

    data_ram #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) data_ram_i (
        .i_clk   (i_clk),
        .i_we    (mem_we),
        .i_width (i_width),
        .i_addr  (mem_addr),
        .i_data  (i_store_data),
        .o_data  (read_word)
    );

    // pick the lowest byte or half of the read word and extend it
    always_comb begin
        case (i_width)
            WIDTH_BYTE: begin
                if (i_unsigned_load) begin
                    load_ext = {{(DATA_W-8){1'b0}}, read_word.bytes[0]};
                end else begin
                    load_ext = {{(DATA_W-8){read_word.bytes[0][7]}}, read_word.bytes[0]};
                end
            end
            WIDTH_HALF: begin
                if (i_unsigned_load) begin
                    load_ext = {{(DATA_W-16){1'b0}}, read_word.halves[0]};
                end else begin
                    load_ext = {{(DATA_W-16){read_word.halves[0][15]}}, read_word.halves[0]};
                end
            end
            default: load_ext = read_word.word;
        endcase
    end

    // MEM/WB register
    // load data only moves on a real load, otherwise it keeps the last value
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_load_data  <= '0;
            o_alu_result <= '0;
            o_reg_dest   <= '0;
            o_mem_to_reg <= 1'b0;
            o_reg_write  <= 1'b0;
        end else if (!i_halt) begin
            if (i_mem_read) begin
                o_load_data <= load_ext;
            end
            o_alu_result <= i_alu_result;
            o_reg_dest   <= i_reg_dest;
            o_mem_to_reg <= i_mem_to_reg;
            o_reg_write  <= i_reg_write;
        end
    end

    // only meaningful while halted, otherwise shows the pipeline's word
    assign o_debug_word = read_word;

endmodule

// File: src/write_back.sv
`timescale 1ns/1ps

module write_back import mem_pipe_pkg::*; (
    // controls from the MEM/WB register
    input  logic                  i_mem_to_reg,
    input  logic                  i_reg_write,

    input  logic [DATA_W-1:0]     i_load_data,
    input  logic [DATA_W-1:0]     i_alu_result,
    input  logic [REG_ADDR_W-1:0] i_reg_dest,

    // register file write port
    output logic                  o_rf_write_enable,
    output logic [REG_ADDR_W-1:0] o_rf_write_addr,
    output logic [DATA_W-1:0]     o_rf_write_data
);

    logic dest_is_zero;

    // $zero is hardwired, a write there is dropped here
    assign dest_is_zero = (i_reg_dest == '0);

    assign o_rf_write_enable = i_reg_write && !dest_is_zero;

    assign o_rf_write_addr = i_reg_dest;

    // loads take the memory value, everything else the ALU result
    always_comb begin
        if (i_mem_to_reg) begin
            o_rf_write_data = i_load_data;
        end else begin
            o_rf_write_data = i_alu_result;
        end
    end

endmodule

// File: src/mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top import mem_pipe_pkg::*; #(
    parameter int MEM_ADDR_W = DEFAULT_MEM_ADDR_W
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_halt,

    input  logic                  i_mem_read,
    input  logic                  i_mem_write,
    input  logic                  i_unsigned_load,
    input  access_width_e         i_width,
    input  logic                  i_mem_to_reg,
    input  logic                  i_reg_write,
    input  logic [DATA_W-1:0]     i_alu_result,
    input  logic [DATA_W-1:0]     i_store_data,
    input  logic [REG_ADDR_W-1:0] i_reg_dest,

    input  logic [DATA_W-1:0]     i_debug_addr,

    output logic                  o_rf_write_enable,
    output logic [REG_ADDR_W-1:0] o_rf_write_addr,
    output logic [DATA_W-1:0]     o_rf_write_data,
    output mem_word_u             o_debug_word
);

    // EX/MEM to memory stage
    logic                  ex_mem_read;
    logic                  ex_mem_write;
    logic                  ex_unsigned_load;
    access_width_e         ex_width;
    logic                  ex_mem_to_reg;
    logic                  ex_reg_write;
    logic [DATA_W-1:0]     ex_alu_result;
    logic [DATA_W-1:0]     ex_store_data;
    logic [REG_ADDR_W-1:0] ex_reg_dest;

    // MEM/WB to write-back
    logic [DATA_W-1:0]     wb_load_data;
    logic [DATA_W-1:0]     wb_alu_result;
    logic [REG_ADDR_W-1:0] wb_reg_dest;
    logic                  wb_mem_to_reg;
    logic                  wb_reg_write;

    ex_mem_register ex_mem_register_i (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_halt          (i_halt),
        .i_mem_read      (i_mem_read),
        .i_mem_write     (i_mem_write),
        .i_unsigned_load (i_unsigned_load),
        .i_width         (i_width),
        .i_mem_to_reg    (i_mem_to_reg),
        .i_reg_write     (i_reg_write),
        .i_alu_result    (i_alu_result),
        .i_store_data    (i_store_data),
        .i_reg_dest      (i_reg_dest),
        .o_mem_read      (ex_mem_read),
        .o_mem_write     (ex_mem_write),
        .o_unsigned_load (ex_unsigned_load),
        .o_width         (ex_width),
        .o_mem_to_reg    (ex_mem_to_reg),
        .o_reg_write     (ex_reg_write),
        .o_alu_result    (ex_alu_result),
        .o_store_data    (ex_store_data),
        .o_reg_dest      (ex_reg_dest)
    );

    mem_access #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) mem_access_i (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_halt          (i_halt),
        .i_mem_read      (ex_mem_read),
        .i_mem_write     (ex_mem_write),
        .i_unsigned_load (ex_unsigned_load),
        .i_width         (ex_width),
        .i_mem_to_reg    (ex_mem_to_reg),
        .i_reg_write     (ex_reg_write),
        .i_alu_result    (ex_alu_result),
        .i_store_data    (ex_store_data),
        .i_reg_dest      (ex_reg_dest),
        .i_debug_addr    (i_debug_addr),
        .o_load_data     (wb_load_data),
        .o_alu_result    (wb_alu_result),
        .o_reg_dest      (wb_reg_dest),
        .o_mem_to_reg    (wb_mem_to_reg),
        .o_reg_write     (wb_reg_write),
        .o_debug_word    (o_debug_word)
    );

    write_back write_back_i (
        .i_mem_to_reg      (wb_mem_to_reg),
        .i_reg_write       (wb_reg_write),
        .i_load_data       (wb_load_data),
        .i_alu_result      (wb_alu_result),
        .i_reg_dest        (wb_reg_dest),
        .o_rf_write_enable (o_rf_write_enable),
        .o_rf_write_addr   (o_rf_write_addr),
        .o_rf_write_data   (o_rf_write_data)
    );

endmodule

// File: testbench/mem_wb_asserts.sv
`timescale 1ns/1ps

module mem_wb_asserts import mem_pipe_pkg::*; #(
    parameter int MEM_ADDR_W = DEFAULT_MEM_ADDR_W
) (
    input logic                  i_clk,
    input logic                  i_reset,
    input logic                  i_halt,
    input logic                  i_mem_we,
    input access_width_e         i_width,
    input logic [MEM_ADDR_W-1:0] i_mem_addr,
    input mem_word_u             i_read_word,
    input logic                  i_mem_to_reg,
    input logic                  i_reg_write
);

    int fail_count = 0;

    // a frozen pipeline leaves the word at a held debug address untouched
    assert property (@(posedge i_clk) disable iff (i_reset)
        (i_halt && $past(i_halt) && $stable(i_mem_addr)) |-> $stable(i_read_word))
        else begin
            $error("memory changed while halted");
            fail_count++;
        end

    // halves sit on even addresses, words on multiples of four
    assert property (@(posedge i_clk) disable iff (i_reset)
        i_mem_we |-> (i_width == WIDTH_BYTE) ||
                     ((i_width == WIDTH_HALF) ? !i_mem_addr[0]
                                               : (i_mem_addr[1:0] == 2'b00)))
        else begin
            $error("misaligned memory write");
            fail_count++;
        end

    assert property (@(posedge i_clk) i_reset |=> (!i_mem_to_reg && !i_reg_write))
        else begin
            $error("write-back controls set after reset");
            fail_count++;
        end

endmodule

bind mem_access mem_wb_asserts #(
    .MEM_ADDR_W (MEM_ADDR_W)
) asserts_i (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_halt       (i_halt),
    .i_mem_we     (mem_we),
    .i_width      (i_width),
    .i_mem_addr   (mem_addr),
    .i_read_word  (read_word),
    .i_mem_to_reg (o_mem_to_reg),
    .i_reg_write  (o_reg_write)
);

// File: testbench/tb_mem_wb.sv
`timescale 1ns/1ps

module tb_mem_wb import mem_pipe_pkg::*; ();

    localparam int MEM_ADDR_W  = 13;
    localparam int RESET_LIMIT = 50;
    localparam int HALT_LIMIT  = 32;

    logic                  i_clk;
    logic                  i_reset;
    logic                  i_halt;
    logic                  i_mem_read;
    logic                  i_mem_write;
    logic                  i_unsigned_load;
    access_width_e         i_width;
    logic                  i_mem_to_reg;
    logic                  i_reg_write;
    logic [DATA_W-1:0]     i_alu_result;
    logic [DATA_W-1:0]     i_store_data;
    logic [REG_ADDR_W-1:0] i_reg_dest;
    logic [DATA_W-1:0]     i_debug_addr;
    logic                  o_rf_write_enable;
    logic [REG_ADDR_W-1:0] o_rf_write_addr;
    logic [DATA_W-1:0]     o_rf_write_data;
    mem_word_u             o_debug_word;

    // reference model state
    logic [7:0]            model_mem [2**MEM_ADDR_W];
    logic [DATA_W-1:0]     model_load;
    logic                  pend_valid;
    access_width_e         pend_width;
    logic [DATA_W-1:0]     pend_addr;
    logic [DATA_W-1:0]     pend_data;

    // expected write-back results with one entry per instruction in flight
    logic                  exp_en [$];
    logic [REG_ADDR_W-1:0] exp_addr [$];
    logic [DATA_W-1:0]     exp_data [$];
    logic                  last_en;
    logic [REG_ADDR_W-1:0] last_addr;
    logic [DATA_W-1:0]     last_data;

    int check_count;
    int error_count;
    int test_start;

    mem_wb_top #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) dut_i (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .i_halt            (i_halt),
        .i_mem_read        (i_mem_read),
        .i_mem_write       (i_mem_write),
        .i_unsigned_load   (i_unsigned_load),
        .i_width           (i_width),
        .i_mem_to_reg      (i_mem_to_reg),
        .i_reg_write       (i_reg_write),
        .i_alu_result      (i_alu_result),
        .i_store_data      (i_store_data),
        .i_reg_dest        (i_reg_dest),
        .i_debug_addr      (i_debug_addr),
        .o_rf_write_enable (o_rf_write_enable),
        .o_rf_write_addr   (o_rf_write_addr),
        .o_rf_write_data   (o_rf_write_data),
        .o_debug_word      (o_debug_word)
    );

    always #5 i_clk = ~i_clk;

    // reset held for 10 cycles
    initial begin
        repeat (10) @(posedge i_clk);
        #1 i_reset = 1'b0;
    end

    initial begin
        #100us;
        $display("timeout: simulation ran past its time limit");
        $display("Checks failed");
        $finish;
    end

    function automatic logic [MEM_ADDR_W-1:0] wrap(input logic [DATA_W-1:0] a, input int k);
        return MEM_ADDR_W'(a + k);
    endfunction

    // halves align to two bytes and words (code 10 too) to four
    function automatic logic [DATA_W-1:0] align(input logic [DATA_W-1:0] a,
                                                input access_width_e w);
        if (w == WIDTH_BYTE) return a;
        if (w == WIDTH_HALF) return {a[DATA_W-1:1], 1'b0};
        return {a[DATA_W-1:2], 2'b00};
    endfunction

    function automatic logic [DATA_W-1:0] model_read(input logic [DATA_W-1:0] a,
                                                     input access_width_e w, input logic uns);
        logic [DATA_W-1:0] b;
        logic [15:0]       h;
        b = align(a, w);
        if (w == WIDTH_BYTE) begin
            return uns ? {24'h0, model_mem[wrap(b, 0)]}
                       : {{24{model_mem[wrap(b, 0)][7]}}, model_mem[wrap(b, 0)]};
        end
        h = {model_mem[wrap(b, 1)], model_mem[wrap(b, 0)]};
        if (w == WIDTH_HALF) begin
            return uns ? {16'h0, h} : {{16{h[15]}}, h};
        end
        return {model_mem[wrap(b, 3)], model_mem[wrap(b, 2)], h};
    endfunction

    function automatic mem_word_u model_word(input logic [DATA_W-1:0] a);
        mem_word_u w;
        for (int k = 0; k < 4; k++) begin
            w.bytes[k] = model_mem[wrap({a[DATA_W-1:2], 2'b00}, k)];
        end
        return w;
    endfunction

    task automatic commit_pending();
        logic [DATA_W-1:0] b;
        if (pend_valid) begin
            b = align(pend_addr, pend_width);
            model_mem[wrap(b, 0)] = pend_data[7:0];
            if (pend_width != WIDTH_BYTE) model_mem[wrap(b, 1)] = pend_data[15:8];
            if (pend_width != WIDTH_BYTE && pend_width != WIDTH_HALF) begin
                model_mem[wrap(b, 2)] = pend_data[23:16];
                model_mem[wrap(b, 3)] = pend_data[31:24];
            end
        end
        pend_valid = 1'b0;
    endtask

    task automatic check_rf(input logic en, input logic [REG_ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data);
        check_count++;
        if (o_rf_write_enable !== en) begin
            $display("CHECK FAILED %0t o_rf_write_enable got %b expected %b",
                     $time, o_rf_write_enable, en);
            error_count++;
        end
        if (o_rf_write_addr !== addr) begin
            $display("CHECK FAILED %0t o_rf_write_addr got %0d expected %0d",
                     $time, o_rf_write_addr, addr);
            error_count++;
        end
        if (o_rf_write_data !== data) begin
            $display("CHECK FAILED %0t o_rf_write_data got %h expected %h",
                     $time, o_rf_write_data, data);
            error_count++;
        end
    endtask

    task automatic check_debug(input mem_word_u exp);
        check_count++;
        if (o_debug_word.word !== exp.word) begin
            $display("CHECK FAILED %0t o_debug_word got %h expected %h",
                     $time, o_debug_word.word, exp.word);
            error_count++;
        end
    endtask

    // a live edge retires the oldest instruction and a frozen edge must hold
    task automatic next_edge();
        @(posedge i_clk);
        #1;
        if (!i_halt) begin
            last_en   = exp_en.pop_front();
            last_addr = exp_addr.pop_front();
            last_data = exp_data.pop_front();
        end
        check_rf(last_en, last_addr, last_data);
    endtask

    task automatic issue(input logic rd, input logic wr, input logic uns,
                         input access_width_e w, input logic m2r, input logic rw,
                         input logic [DATA_W-1:0] alu, input logic [DATA_W-1:0] st,
                         input logic [REG_ADDR_W-1:0] dest);
        next_edge();
        commit_pending();
        if (rd) model_load = model_read(alu, w, uns);
        exp_en.push_back(rw && (dest != 0));
        exp_addr.push_back(dest);
        exp_data.push_back(m2r ? model_load : alu);
        pend_valid = wr;
        pend_width = w;
        pend_addr  = alu;
        pend_data  = st;
        i_halt          = 1'b0;
        i_mem_read      = rd;
        i_mem_write     = wr;
        i_unsigned_load = uns;
        i_width         = w;
        i_mem_to_reg    = m2r;
        i_reg_write     = rw;
        i_alu_result    = alu;
        i_store_data    = st;
        i_reg_dest      = dest;
    endtask

    // addresses stay in the 64-byte window that was filled at the start
    function automatic logic [DATA_W-1:0] rand_addr();
        logic [DATA_W-1:0] r;
        r = $urandom;
        r[MEM_ADDR_W-1:6] = '0;
        return r;
    endfunction

    task automatic issue_random();
        access_width_e w;
        int            kind;
        w = access_width_e'($urandom % 4);
        kind = $urandom % 3;
        if (kind == 0) begin
            issue(0, 0, 0, w, 0, $urandom, $urandom, $urandom, $urandom);
        end else if (kind == 1) begin
            issue(0, 1, 0, w, 0, 0, rand_addr(), $urandom, $urandom);
        end else begin
            issue(1, 0, $urandom, w, 1, 1, rand_addr(), $urandom, $urandom);
        end
    endtask

    task automatic halt_cycle(input logic [DATA_W-1:0] dbg);
        next_edge();
        i_halt       = 1'b1;
        i_debug_addr = dbg;
        #2;
        check_debug(model_word(dbg));
    endtask

    task automatic hold_pipeline(input int cycles);
        int n;
        n = 0;
        // the first two reads look at the word the pending store will change
        while (n < cycles && n < HALT_LIMIT) begin
            halt_cycle((n < 2 && pend_valid) ? pend_addr : rand_addr());
            n++;
        end
        if (n < cycles) begin
            $display("halt period ran past its cycle limit");
            error_count++;
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, error_count - test_start);
        test_start = error_count;
    endtask

    initial begin
        int n;
        logic [DATA_W-1:0] a;
        access_width_e     w;
        void'($urandom(32'hc088adab));
        i_clk = 1'b0;
        i_reset = 1'b1;
        i_halt = 1'b0;
        i_mem_read = 1'b0;
        i_mem_write = 1'b0;
        i_unsigned_load = 1'b0;
        i_width = WIDTH_BYTE;
        i_mem_to_reg = 1'b0;
        i_reg_write = 1'b0;
        i_alu_result = '0;
        i_store_data = '0;
        i_reg_dest = '0;
        i_debug_addr = '0;
        model_load = '0;
        pend_valid = 1'b0;
        check_count = 0;
        error_count = 0;
        test_start = 0;

        n = 0;
        while (i_reset && n < RESET_LIMIT) begin
            @(posedge i_clk);
            n++;
        end
        #1;
        if (i_reset) begin
            $display("reset was never released");
            error_count++;
        end
        check_rf(1'b0, '0, '0);
        report_test("reset_state");

        // bubbles latched while in reset
        for (int k = 0; k < 2; k++) begin
            exp_en.push_back(1'b0);
            exp_addr.push_back('0);
            exp_data.push_back('0);
        end

        for (int k = 0; k < 40; k++) begin
            issue(0, 0, 0, WIDTH_WORD, 0, $urandom, $urandom, $urandom, $urandom);
        end
        report_test("alu_pass_through");

        for (int k = 0; k < 64; k += 4) begin
            a = k;
            issue(0, 1, 0, WIDTH_WORD, 0, 0, a, {a[15:0] ^ 16'h5a3c, ~a[15:0]}, 0);
        end
        for (int k = 0; k < 60; k++) issue_random();
        for (int k = 0; k < 12; k++) begin
            a = rand_addr();
            w = access_width_e'($urandom % 4);
            issue(0, 1, 0, w, 0, 0, a, $urandom, 0);
            issue(1, 0, $urandom, w, 1, 1, a, 0, $urandom);
        end
        report_test("store_load_widths");

        for (int k = 0; k < 20; k++) issue_random();
        issue(0, 1, 0, WIDTH_WORD, 0, 0, rand_addr(), $urandom, 0);
        hold_pipeline(2 + $urandom % 7);
        for (int k = 0; k < 20; k++) issue_random();
        report_test("halt_freeze");

        issue(0, 1, 0, WIDTH_HALF, 0, 0, rand_addr(), $urandom, 0);
        hold_pipeline(12);
        issue_random();
        report_test("debug_read");

        issue(1, 0, 0, WIDTH_WORD, 1, 1, rand_addr(), 0, 5'd7);
        issue(0, 0, 1, WIDTH_BYTE, 0, 1, rand_addr(), 0, 5'd8);
        issue(0, 0, 0, WIDTH_HALF, 1, 1, rand_addr(), 0, 5'd9);
        for (int k = 0; k < 2; k++) issue(0, 0, 0, WIDTH_BYTE, 0, 0, 0, 0, 0);
        report_test("load_without_read");

        error_count += dut_i.mem_access_i.asserts_i.fail_count;
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: sim.f
common/mem_pipe_pkg.sv
src/ex_mem_register.sv
data_memory/data_ram.sv
data_memory/mem_access.sv
src/write_back.sv
src/mem_wb_top.sv
testbench/mem_wb_asserts.sv
testbench/tb_mem_wb.sv

// File: Bender.yml
package:
  name: mem_wb

sources:
  - common/mem_pipe_pkg.sv
  - src/ex_mem_register.sv
  - data_memory/data_ram.sv
  - data_memory/mem_access.sv
  - src/write_back.sv
  - src/mem_wb_top.sv
  - target: test
    files:
      - testbench/mem_wb_asserts.sv
      - testbench/tb_mem_wb.sv
